// File: sim.f
+incdir+verilog
verilog/zx_video_pkg.sv
verilog/zx_bus_pkg.sv
verilog/zx_screen.sv
verilog/zx_ports.sv
verilog/zx_ula.sv
verif/zx_ula_chk.sv
verif/zx_ula_monitor.sv
verif/tb_zx_ula.sv

// File: verif/tb_zx_ula.sv
// port fe table on the right border of line 0, then two free-running frames
// all comparing is done in zx_ula_monitor, this module only drives and sums up
`default_nettype none
`timescale 1ns/1ps
`include "zx_defines.svh"

module tb_zx_ula;
    import zx_bus_pkg::*;
    import zx_video_pkg::*;

    localparam int LINE_CYC  = `ZX_LINE_PIXELS * `ZX_PIX_DIV;
    localparam int FRAME_CYC = `ZX_FRAME_LINES * LINE_CYC;
    localparam int ROW_CYC   = 6;       // 2 strobe cycles, 4 idle
    localparam int LEAD_CYC  = `ZX_PAPER_W * `ZX_PIX_DIV;

    typedef struct packed {
        logic [127:0] name;
        logic         rd_op;            // 1 read, 0 write
        logic         rnd;              // data and kd from the generator
        addr_t        addr;
        byte_t        data;
        keyrow_t      kd;
        logic         tape;
        byte_t        exp;              // read byte, or {snd, mic} for a write
    } row_s;

    logic         clk28;
    logic         rst_n;
    addr_t        xa;
    byte_t        xd_in;
    logic         n_iorq;
    logic         n_rd;
    logic         n_wr;
    keyrow_t      kd;
    logic         tape_in;
    byte_t        xd_out;
    logic         xd_oe;
    logic         hsync;
    logic         vsync;
    logic         csync;
    chan_t        r;
    chan_t        g;
    chan_t        b;
    logic         n_int;
    logic         snd;
    logic         mic;
    logic         chk_rd;
    logic         chk_wr;
    logic         chk_oe;
    logic [127:0] chk_name;
    byte_t        chk_exp;
    int           row_errs;
    int           timing_errs;
    int           row_checks;
    int           int_pulses;
    int           nonblack;
    int           other_errs;
    int           cycles;
    int           limit;
    logic [31:0]  rng_state;
    row_s         rows[$];

    zx_ula DUT (
        .clk28(clk28), .rst_n(rst_n), .xa(xa), .xd_in(xd_in),
        .n_iorq(n_iorq), .n_rd(n_rd), .n_wr(n_wr), .kd(kd), .tape_in(tape_in),
        .xd_out(xd_out), .xd_oe(xd_oe), .hsync(hsync), .vsync(vsync), .csync(csync),
        .r(r), .g(g), .b(b), .n_int(n_int), .snd(snd), .mic(mic)
    );

    zx_ula_monitor monitor (
        .clk28(clk28), .rst_n(rst_n), .xa(xa), .xd_in(xd_in), .n_iorq(n_iorq),
        .n_wr(n_wr), .xd_out(xd_out), .xd_oe(xd_oe), .hsync(hsync), .vsync(vsync),
        .csync(csync), .r(r), .g(g), .b(b), .n_int(n_int), .snd(snd), .mic(mic),
        .chk_rd(chk_rd), .chk_wr(chk_wr), .chk_oe(chk_oe), .chk_name(chk_name),
        .chk_exp(chk_exp), .row_errs(row_errs), .timing_errs(timing_errs),
        .row_checks(row_checks), .int_pulses(int_pulses), .nonblack(nonblack)
    );

    always #20 clk28 = ~clk28;

    always @(posedge clk28) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic add_row(input logic [127:0] name, input logic rd_op, input logic rnd,
                           input addr_t addr, input byte_t data, input keyrow_t k,
                           input logic tape, input byte_t exp);
        row_s row;
        row.name  = name;
        row.rd_op = rd_op;
        row.rnd   = rnd;
        row.addr  = addr;
        row.data  = data;
        row.kd    = k;
        row.tape  = tape;
        row.exp   = exp;
        rows.push_back(row);
    endtask

    task automatic load_table();
        add_row("rd_idle",     1'b1, 1'b0, 16'hfefe, 8'h00, 5'h1f, 1'b0, 8'hbf);
        add_row("rd_key_a",    1'b1, 1'b0, 16'hfdfe, 8'h00, 5'h1e, 1'b1, 8'hfe);
        add_row("rd_odd_port", 1'b1, 1'b0, 16'h00ff, 8'h00, 5'h00, 1'b1, 8'h00);
        add_row("wr_blue",     1'b0, 1'b0, 16'h00fe, 8'h01, 5'h1f, 1'b0, 8'h00);
        add_row("wr_mic",      1'b0, 1'b0, 16'h00fe, 8'h08, 5'h1f, 1'b0, 8'h03);
        add_row("wr_beep",     1'b0, 1'b0, 16'h00fe, 8'h10, 5'h1f, 1'b0, 8'h02);
        add_row("wr_both_red", 1'b0, 1'b0, 16'h00fe, 8'h1a, 5'h1f, 1'b0, 8'h01);
        add_row("wr_odd_port", 1'b0, 1'b0, 16'h00ff, 8'h07, 5'h1f, 1'b0, 8'h01);  // ignored
        add_row("rd_tape",     1'b1, 1'b0, 16'h7ffe, 8'h00, 5'h15, 1'b1, 8'hf5);
        add_row("wr_white",    1'b0, 1'b0, 16'h00fe, 8'h07, 5'h1f, 1'b0, 8'h00);
        add_row("rd_rand_0",   1'b1, 1'b1, 16'hbffe, 8'h00, 5'h00, 1'b0, 8'h00);
        add_row("wr_rand_0",   1'b0, 1'b1, 16'h00fe, 8'h00, 5'h00, 1'b0, 8'h00);
        add_row("rd_rand_1",   1'b1, 1'b1, 16'hdffe, 8'h00, 5'h00, 1'b1, 8'h00);
        add_row("wr_rand_1",   1'b0, 1'b1, 16'h00fe, 8'h00, 5'h00, 1'b0, 8'h00);
        add_row("rd_rand_2",   1'b1, 1'b1, 16'heffe, 8'h00, 5'h00, 1'b0, 8'h00);
        add_row("wr_rand_2",   1'b0, 1'b1, 16'h00fe, 8'h00, 5'h00, 1'b0, 8'h00);
        add_row("wr_green",    1'b0, 1'b0, 16'h00fe, 8'h04, 5'h1f, 1'b0, 8'h00);
    endtask

    task automatic apply_row(input row_s row_in);
        row_s        row;
        logic [31:0] rv;
        row = row_in;
        if (row.rnd) begin
            rv       = next_rand();
            row.data = rv[7:0];
            row.kd   = rv[12:8];
            // read byte is 1, tape, 1, kd; a write gives snd = d4 ^ d3 and mic = d3
            if (row.rd_op)
                row.exp = {1'b1, row.tape, 1'b1, row.kd};
            else
                row.exp = {6'b0, row.data[4] ^ row.data[3], row.data[3]};
        end
        @(posedge clk28);
        xa       <= row.addr;
        xd_in    <= row.data;
        kd       <= row.kd;
        tape_in  <= row.tape;
        n_iorq   <= 1'b0;
        n_rd     <= ~row.rd_op;
        n_wr     <= row.rd_op;
        chk_name <= row.name;
        chk_exp  <= row.exp;
        chk_oe   <= ~row.addr[0];
        chk_rd   <= row.rd_op;
        @(posedge clk28);
        chk_rd <= 1'b0;
        @(posedge clk28);
        n_iorq <= 1'b1;
        n_rd   <= 1'b1;
        n_wr   <= 1'b1;
        chk_wr <= ~row.rd_op;           // write landed one edge ago
        @(posedge clk28);
        chk_wr <= 1'b0;
        repeat (2) @(posedge clk28);
    endtask

    initial begin
        clk28     = 1'b0;
        rst_n     = 1'b0;
        xa        = '0;
        xd_in     = '0;
        n_iorq    = 1'b1;
        n_rd      = 1'b1;
        n_wr      = 1'b1;
        kd        = 5'h1f;
        tape_in   = 1'b0;
        chk_rd    = 1'b0;
        chk_wr    = 1'b0;
        chk_oe    = 1'b0;
        chk_name  = '0;
        chk_exp   = '0;
        rng_state = 32'd39;
        load_table();
        limit = rows.size() * ROW_CYC + 3 * FRAME_CYC + 1000;
        repeat (5) @(posedge clk28);
        rst_n <= 1'b1;
        // beam leaves the paper of line 0, so each written colour shows on rgb
        repeat (LEAD_CYC) @(posedge clk28);
        foreach (rows[i]) apply_row(rows[i]);
        repeat (2 * FRAME_CYC) @(posedge clk28);
        @(negedge clk28);
        if (row_checks != rows.size()) begin
            other_errs++;
            $display("only %0d of %0d table rows were checked", row_checks, rows.size());
        end
        if (int_pulses < 2) begin
            other_errs++;
            $display("fewer than two frame interrupts were seen, got %0d", int_pulses);
        end
        if (nonblack == 0) begin
            other_errs++;
            $display("the border colour never appeared on rgb");
        end
        $display("errors: %0d row, %0d timing, %0d other", row_errs, timing_errs, other_errs);
        if (row_errs + timing_errs + other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/zx_ula_chk.sv
// assertions on the ula pins, bound into every zx_ula instance
// outputs reset synchronously, so reset values show one edge after rst_n is low
`default_nettype none
`timescale 1ns/1ps

module zx_ula_chk (
    input logic clk28,
    input logic rst_n,
    input logic n_iorq,
    input logic n_rd,
    input logic xd_oe,
    input logic hsync,
    input logic vsync,
    input logic csync,
    input logic n_int
);

    reset_idle: assert property (@(posedge clk28) !rst_n |=> (n_int && hsync && vsync))
        else $error("n_int, hsync or vsync low while in reset");

    // read enable only during an io read cycle
    oe_needs_read: assert property (@(posedge clk28) xd_oe |-> (!n_iorq && !n_rd))
        else $error("xd_oe high without iorq and rd");

    csync_is_and: assert property (@(posedge clk28) disable iff (!rst_n)
                                   csync == (hsync & vsync))
        else $error("csync differs from hsync and vsync combined");

endmodule

bind zx_ula zx_ula_chk chk0 (
    .clk28(clk28), .rst_n(rst_n), .n_iorq(n_iorq), .n_rd(n_rd), .xd_oe(xd_oe),
    .hsync(hsync), .vsync(vsync), .csync(csync), .n_int(n_int)
);

`default_nettype wire

// File: verif/zx_ula_monitor.sv
// samples the ula pins on the falling clk28 edge, after rising-edge stimulus settles
// border is tracked from the bus pins, so any port fe write is followed
`default_nettype none
`timescale 1ns/1ps
`include "zx_defines.svh"

module zx_ula_monitor (
    input  logic                clk28,
    input  logic                rst_n,
    input  zx_bus_pkg::addr_t   xa,
    input  zx_bus_pkg::byte_t   xd_in,
    input  logic                n_iorq,
    input  logic                n_wr,
    input  zx_bus_pkg::byte_t   xd_out,
    input  logic                xd_oe,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                csync,
    input  zx_video_pkg::chan_t r,
    input  zx_video_pkg::chan_t g,
    input  zx_video_pkg::chan_t b,
    input  logic                n_int,
    input  logic                snd,
    input  logic                mic,
    input  logic                chk_rd,
    input  logic                chk_wr,
    input  logic                chk_oe,
    input  logic [127:0]        chk_name,
    input  zx_bus_pkg::byte_t   chk_exp,
    output int                  row_errs,
    output int                  timing_errs,
    output int                  row_checks,
    output int                  int_pulses,
    output int                  nonblack
);
    import zx_video_pkg::*;

    localparam int LINE_CYC  = `ZX_LINE_PIXELS * `ZX_PIX_DIV;
    localparam int FRAME_CYC = `ZX_FRAME_LINES * LINE_CYC;
    localparam int HS_CYC    = `ZX_HSYNC_LEN * `ZX_PIX_DIV;
    localparam int VS_CYC    = `ZX_VSYNC_LEN * LINE_CYC;
    localparam int INT_CYC   = `ZX_INT_LEN * `ZX_PIX_DIV;
    localparam int INT_FIRST = `ZX_INT_LINE * LINE_CYC;

    int         cyc;                    // cycles since reset release
    int         h_fall;
    int         v_fall;
    int         i_fall;
    int         pend_start;
    int         age;                    // cycles since the border changed
    logic       h_q;
    logic       v_q;
    logic       i_q;
    logic       h_seen;
    logic       v_seen;
    logic       i_seen;
    logic       pend;                   // non-zero border not yet seen on rgb
    border_t    cur_b;
    border_t    prev_b;
    logic [5:0] rgb_now;

    // bit 1 red, bit 2 green, bit 0 blue, each at full level
    function automatic logic [5:0] colour_of(input border_t idx);
        return {idx[1] ? 2'd3 : 2'd0, idx[2] ? 2'd3 : 2'd0, idx[0] ? 2'd3 : 2'd0};
    endfunction

    task automatic report_timing(input string what, input int exp, input int act);
        timing_errs++;
        $display("mismatch %s: expected %0d actual %0d", what, exp, act);
    endtask

    always @(negedge clk28) begin
        if (!rst_n) begin
            cyc    = 0;
            h_q    = 1'b1;
            v_q    = 1'b1;
            i_q    = 1'b1;
            h_seen = 1'b0;
            v_seen = 1'b0;
            i_seen = 1'b0;
            pend   = 1'b0;
            cur_b  = '0;
            prev_b = '0;
            age    = 100;
        end else begin
            cyc++;
            if (chk_rd) begin
                row_checks++;
                if (xd_oe !== chk_oe) begin
                    row_errs++;
                    $display("mismatch %0s: expected xd_oe %b actual %b", chk_name, chk_oe, xd_oe);
                end else if (chk_oe && xd_out !== chk_exp) begin
                    row_errs++;
                    $display("mismatch %0s: expected %h actual %h", chk_name, chk_exp, xd_out);
                end
            end
            if (chk_wr) begin
                row_checks++;
                if ({snd, mic} !== chk_exp[1:0]) begin
                    row_errs++;
                    $display("mismatch %0s: expected snd,mic %b actual %b",
                             chk_name, chk_exp[1:0], {snd, mic});
                end
            end
            // port fe write seen on the pins, loads on the coming edge
            if (!n_iorq && !n_wr && !xa[0]) begin
                if (xd_in[2:0] != cur_b) begin
                    prev_b = cur_b;
                    cur_b  = xd_in[2:0];
                    age    = 0;
                end
                if (cur_b == 0) begin
                    pend = 1'b0;
                end else if (!pend) begin
                    pend       = 1'b1;
                    pend_start = cyc;
                end
            end
            rgb_now = {r, g, b};
            if (rgb_now !== 6'd0) begin
                nonblack++;
                if (rgb_now === colour_of(cur_b))
                    pend = 1'b0;
                if (rgb_now !== colour_of(cur_b) &&
                    !(age < 5 && rgb_now === colour_of(prev_b))) begin
                    timing_errs++;
                    $display("mismatch rgb_border: expected %h actual %h",
                             colour_of(cur_b), rgb_now);
                end
            end
            if (pend && cyc - pend_start > LINE_CYC) begin
                timing_errs++;
                $display("border %0d was written but did not show on rgb within a line", cur_b);
                pend = 1'b0;
            end
            if (age < 100)
                age++;
            if (csync !== (hsync & vsync)) begin
                timing_errs++;
                $display("mismatch csync: expected %b actual %b", hsync & vsync, csync);
            end
            if (h_q && !hsync) begin
                if (h_seen && cyc - h_fall != LINE_CYC)
                    report_timing("hsync_period", LINE_CYC, cyc - h_fall);
                h_fall = cyc;
                h_seen = 1'b1;
            end
            if (!h_q && hsync && h_seen && cyc - h_fall != HS_CYC)
                report_timing("hsync_low", HS_CYC, cyc - h_fall);
            if (v_q && !vsync) begin
                v_fall = cyc;
                v_seen = 1'b1;
            end
            if (!v_q && vsync && v_seen && cyc - v_fall != VS_CYC)
                report_timing("vsync_low", VS_CYC, cyc - v_fall);
            if (i_q && !n_int) begin
                if (i_seen && cyc - i_fall != FRAME_CYC)
                    report_timing("n_int_period", FRAME_CYC, cyc - i_fall);
                // divider and output register add a few cycles after reset
                if (!i_seen && (cyc < INT_FIRST || cyc > INT_FIRST + 4))
                    report_timing("n_int_first", INT_FIRST, cyc);
                i_fall = cyc;
                i_seen = 1'b1;
            end
            if (!i_q && n_int && i_seen) begin
                int_pulses++;
                if (cyc - i_fall != INT_CYC)
                    report_timing("n_int_low", INT_CYC, cyc - i_fall);
            end
            h_q = hsync;
            v_q = vsync;
            i_q = n_int;
        end
    end

endmodule

`default_nettype wire

// File: verilog/zx_bus_pkg.sv
// z80 bus side types, strobes already converted to active high
`default_nettype none

package zx_bus_pkg;

    typedef logic [15:0] addr_t;

    typedef logic [7:0] byte_t;

    // keyboard half-row, a pressed key reads as 0
    typedef logic [4:0] keyrow_t;

    // plain levels, no handshake
    typedef struct packed {
        addr_t a;
        byte_t d;       // write data
        logic  iorq;
        logic  rd;
        logic  wr;
    } cpu_bus_s;

endpackage

`default_nettype wire

// File: verilog/zx_defines.svh
// 48k timing constants in pixels (7 MHz) and lines
// all windows are half-open, paper starts at pixel 0 line 0
`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

// frame geometry
`define ZX_LINE_PIXELS 448
`define ZX_FRAME_LINES 312
`define ZX_PIX_DIV     4        // clk28 cycles per pixel

`define ZX_HSYNC_START 344
`define ZX_HSYNC_LEN   32
`define ZX_VSYNC_START 248
`define ZX_VSYNC_LEN   4

// frame interrupt, low on one line for the first pixels
`define ZX_INT_LINE    248
`define ZX_INT_LEN     32

`define ZX_PAPER_W     256
`define ZX_PAPER_H     192

`define ZX_BLANK_HSTART 320
`define ZX_BLANK_HEND   416
`define ZX_BLANK_VSTART 240
`define ZX_BLANK_VEND   256

`define ZX_CHAN_ON     2'd3     // level for a set border bit

`endif

// File: verilog/zx_ports.sv
// port fe of the 48k ula, any even address with iorq selects it
// read data is combinational, the write registers load one clk28 later
`default_nettype none
`timescale 1ns/1ps

module zx_ports (
    input  logic                   clk28,
    input  logic                   rst_n,
    input  zx_bus_pkg::cpu_bus_s   bus,
    input  zx_bus_pkg::keyrow_t    kd,
    input  logic                   tape_in,
    output zx_bus_pkg::byte_t      xd_out,
    output logic                   xd_oe,
    output zx_video_pkg::border_t  border,
    output logic                   mic,
    output logic                   snd
);
    import zx_bus_pkg::*;
    import zx_video_pkg::*;

    logic    port_fe;
    logic    fe_wr;
    logic    fe_rd;
    border_t border_q;
    logic    mic_q;
    logic    beeper_q;

    // partial decode, only a0 is looked at
    assign port_fe = bus.iorq & ~bus.a[0];
    assign fe_wr   = port_fe & bus.wr;
    assign fe_rd   = port_fe & bus.rd;

    // a held strobe just reloads the same value
    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            border_q <= '0;
            mic_q    <= 1'b0;
            beeper_q <= 1'b0;
        end else if (fe_wr) begin
            border_q <= border_t'(bus.d[2:0]);
            mic_q    <= bus.d[3];
            beeper_q <= bus.d[4];
        end
    end

    assign border = border_q;
    assign mic    = mic_q;

    // beeper and mic share the one speaker line
    assign snd = beeper_q ^ mic_q;

    // bits 7 and 5 float high on a real 48k
    assign xd_out = {1'b1, tape_in, 1'b1, kd};
    assign xd_oe  = fe_rd;

endmodule

`default_nettype wire

// File: verilog/zx_screen.sv
// 48k screen timing, 448 pixels x 312 lines, pixel rate is clk28/4
// no video fetch, paper and blanking are shown black
`default_nettype none
`timescale 1ns/1ps
`include "zx_defines.svh"

module zx_screen (
    input  logic                  clk28,
    input  logic                  rst_n,
    input  zx_video_pkg::border_t border,
    output zx_video_pkg::sync_s   sync,
    output zx_video_pkg::rgb_s    rgb,
    output logic                  n_int
);
    import zx_video_pkg::*;

    logic [1:0] pix_div;
    logic       pix_en;
    hcount_t    hcount;
    vcount_t    vcount;
    logic       line_end;
    logic       frame_end;
    logic       hsync_win;
    logic       vsync_win;
    logic       int_win;
    logic       blank_win;
    logic       paper_win;
    rgb_s       border_rgb;

    // each set border bit drives its channel to full level
    function automatic rgb_s border_to_rgb(input border_t idx);
        rgb_s c;
        c.r = idx[1] ? chan_t'(`ZX_CHAN_ON) : chan_t'(0);
        c.g = idx[2] ? chan_t'(`ZX_CHAN_ON) : chan_t'(0);
        c.b = idx[0] ? chan_t'(`ZX_CHAN_ON) : chan_t'(0);
        return c;
    endfunction

    // pixel enable on the last clk28 of every pixel
    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            pix_div <= '0;
        end else begin
            pix_div <= pix_div + 2'd1;
        end
    end

    assign pix_en    = (pix_div == 2'(`ZX_PIX_DIV - 1));
    assign line_end  = (hcount == hcount_t'(`ZX_LINE_PIXELS - 1));
    assign frame_end = (vcount == vcount_t'(`ZX_FRAME_LINES - 1));

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (pix_en) begin
            if (line_end) begin
                hcount <= '0;
                vcount <= frame_end ? '0 : vcount + 1'b1;
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // window decode straight off the counters
    assign hsync_win = (hcount >= hcount_t'(`ZX_HSYNC_START)) &&
                       (hcount <  hcount_t'(`ZX_HSYNC_START + `ZX_HSYNC_LEN));
    assign vsync_win = (vcount >= vcount_t'(`ZX_VSYNC_START)) &&
                       (vcount <  vcount_t'(`ZX_VSYNC_START + `ZX_VSYNC_LEN));

    // 32 pixels on one line, 128 clk28 cycles
    assign int_win = (vcount == vcount_t'(`ZX_INT_LINE)) &&
                     (hcount <  hcount_t'(`ZX_INT_LEN));

    assign blank_win = ((hcount >= hcount_t'(`ZX_BLANK_HSTART)) &&
                        (hcount <  hcount_t'(`ZX_BLANK_HEND))) ||
                       ((vcount >= vcount_t'(`ZX_BLANK_VSTART)) &&
                        (vcount <  vcount_t'(`ZX_BLANK_VEND)));

    assign paper_win = (hcount < hcount_t'(`ZX_PAPER_W)) &&
                       (vcount < vcount_t'(`ZX_PAPER_H));

    assign border_rgb = border_to_rgb(border);

    // output stage, one clk28 behind the counters
    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            sync.hsync <= 1'b1;
            sync.vsync <= 1'b1;
            sync.csync <= 1'b1;
            n_int      <= 1'b1;
            rgb        <= '0;
        end else begin
            sync.hsync <= ~hsync_win;
            sync.vsync <= ~vsync_win;
            sync.csync <= ~(hsync_win | vsync_win);   // same as hsync & vsync
            n_int      <= ~int_win;
            if (blank_win || paper_win) begin
                rgb <= '0;
            end else begin
                rgb <= border_rgb;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/zx_ula.sv
// 48k ula timing and port fe on clk28, bus strobes are active low pins
// rst_n reaches both blocks directly
`default_nettype none
`timescale 1ns/1ps

module zx_ula (
    input  logic                 clk28,
    input  logic                 rst_n,
    input  zx_bus_pkg::addr_t    xa,
    input  zx_bus_pkg::byte_t    xd_in,
    input  logic                 n_iorq,
    input  logic                 n_rd,
    input  logic                 n_wr,
    input  zx_bus_pkg::keyrow_t  kd,
    input  logic                 tape_in,
    output zx_bus_pkg::byte_t    xd_out,
    output logic                 xd_oe,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 csync,
    output zx_video_pkg::chan_t  r,
    output zx_video_pkg::chan_t  g,
    output zx_video_pkg::chan_t  b,
    output logic                 n_int,
    output logic                 snd,
    output logic                 mic
);
    import zx_bus_pkg::*;
    import zx_video_pkg::*;

    cpu_bus_s bus;
    border_t  border;
    sync_s    sync;
    rgb_s     rgb;

    assign bus.a    = xa;
    assign bus.d    = xd_in;
    assign bus.iorq = ~n_iorq;
    assign bus.rd   = ~n_rd;
    assign bus.wr   = ~n_wr;

    zx_ports ports0 (
        .clk28   (clk28),
        .rst_n   (rst_n),
        .bus     (bus),
        .kd      (kd),
        .tape_in (tape_in),
        .xd_out  (xd_out),
        .xd_oe   (xd_oe),
        .border  (border),
        .mic     (mic),
        .snd     (snd)
    );

    zx_screen screen0 (
        .clk28  (clk28),
        .rst_n  (rst_n),
        .border (border),
        .sync   (sync),
        .rgb    (rgb),
        .n_int  (n_int)
    );

    assign {hsync, vsync, csync} = {sync.hsync, sync.vsync, sync.csync};
    assign {r, g, b}             = {rgb.r, rgb.g, rgb.b};

endmodule

`default_nettype wire

// File: verilog/zx_video_pkg.sv
// video side types, counters and colour outputs of the ula
`default_nettype none

package zx_video_pkg;

    // pixel within a line, 0..447
    typedef logic [8:0] hcount_t;

    // line within a frame, 0..311
    typedef logic [8:0] vcount_t;

    // border index: bit 0 blue, bit 1 red, bit 2 green
    typedef logic [2:0] border_t;

    // one output colour channel, 0 is off and 3 is full
    typedef logic [1:0] chan_t;

    // all active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic csync;
    } sync_s;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_s;

endpackage

`default_nettype wire
